// File: hdl/udp_pkg.sv
`default_nettype none

package udp_pkg;

    // stream and address types
    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len_t;

    // header geometry
    localparam int HDR_BYTES     = 42;
    localparam int IP_HDR_BYTES  = 20;
    localparam int UDP_HDR_BYTES = 8;

    // protocol constants
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam byte_t       IP_PROTO_UDP  = 8'd17;
    localparam byte_t       IP_TTL        = 8'd64;

    // decoded header, fields in wire order, first field in the top bits
    typedef struct packed {
        // ethernet
        mac_t        dest_mac;
        mac_t        src_mac;
        logic [15:0] eth_type;
        // ipv4
        byte_t       ver_ihl;
        byte_t       tos;
        logic [15:0] ip_length;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        byte_t       ttl;
        byte_t       protocol;
        logic [15:0] ip_checksum;
        ip_t         src_ip;
        ip_t         dest_ip;
        // udp
        port_t       src_port;
        port_t       dest_port;
        len_t        udp_length;
        logic [15:0] udp_checksum;
    } hdr_fields_t;

    // same 336 bits seen as wire bytes, bytes[0] is the first byte on the wire
    typedef union packed {
        hdr_fields_t                  fields;
        byte_t [0:HDR_BYTES-1]        bytes;
    } hdr_u;

endpackage

`default_nettype wire

// File: hdl/udp_frame_parser.sv
`default_nettype none

module udp_frame_parser (
    input  wire                  clk,
    input  wire                  rst,

    // byte stream in
    input  wire udp_pkg::byte_t  rx_data,
    input  wire                  rx_valid,
    input  wire                  rx_last,
    output logic                 rx_ready,

    // captured header
    output udp_pkg::hdr_u        hdr,
    output logic                 hdr_done,

    // bytes after the header
    output udp_pkg::byte_t       body_data,
    output logic                 body_valid,
    output logic                 body_last,
    input  wire                  body_ready,

    output logic                 short_last
);

    localparam logic [5:0] HDR_COUNT = 6'(udp_pkg::HDR_BYTES);

    // header bytes taken so far in this frame
    logic [5:0] cnt;
    logic       rx_xfer;

    assign hdr_done = (cnt == HDR_COUNT);

    // header capture always accepts, body follows the filter
    assign rx_ready = hdr_done ? body_ready : 1'b1;
    assign rx_xfer  = rx_valid && rx_ready;

    assign body_data  = rx_data;
    assign body_valid = rx_valid && hdr_done;
    assign body_last  = rx_last;

    // frame ended with the header still open
    assign short_last = rx_xfer && rx_last && !hdr_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (rx_xfer) begin
            if (rx_last) begin
                cnt <= '0;
            end else if (!hdr_done) begin
                cnt <= cnt + 6'd1;
            end
        end
    end

    // header bytes land in wire order
    always_ff @(posedge clk) begin
        if (rx_xfer && !hdr_done) begin
            hdr.bytes[cnt] <= rx_data;
        end
    end

    // counter must stop at the header size and never wrap into the body
    cnt_bound_a: assert property (
        @(posedge clk) disable iff (rst)
        cnt <= HDR_COUNT
    );

endmodule

`default_nettype wire

// File: hdl/udp_port_filter.sv
`default_nettype none

module udp_port_filter #(
    parameter udp_pkg::port_t LOCAL_PORT = 16'd1234
) (
    input  wire                  clk,
    input  wire                  rst,

    input  wire udp_pkg::hdr_u   hdr,
    input  wire                  hdr_done,
    input  wire                  short_last,

    input  wire udp_pkg::byte_t  body_data,
    input  wire                  body_valid,
    input  wire                  body_last,
    output logic                 body_ready,

    output udp_pkg::byte_t       rx_payload_data,
    output logic                 rx_payload_valid,
    output logic                 rx_payload_last,
    input  wire                  rx_payload_ready,
    output udp_pkg::len_t        rx_payload_length
);

    logic match_now;
    logic decided;
    logic deliver_reg;
    logic deliver;

    // ipv4, udp and our port, only meaningful once the header is complete
    assign match_now = hdr_done
                    && (hdr.fields.eth_type  == udp_pkg::ETH_TYPE_IPV4)
                    && (hdr.fields.protocol  == udp_pkg::IP_PROTO_UDP)
                    && (hdr.fields.dest_port == LOCAL_PORT);

    // first beat uses the live match, later beats the stored one
    assign deliver = decided ? deliver_reg : match_now;

    assign rx_payload_data   = body_data;
    assign rx_payload_valid  = body_valid && deliver;
    assign rx_payload_last   = body_last;
    assign rx_payload_length = hdr.fields.udp_length - 16'(udp_pkg::UDP_HDR_BYTES);

    // dropped frames drain at full rate
    assign body_ready = deliver ? rx_payload_ready : 1'b1;

    always_ff @(posedge clk) begin
        if (rst || short_last) begin
            decided     <= 1'b0;
            deliver_reg <= 1'b0;
        end else if (body_valid && body_ready && body_last) begin
            decided     <= 1'b0;
        end else if (body_valid && !decided) begin
            decided     <= 1'b1;
            deliver_reg <= match_now;
        end
    end

    // stored decision must still agree with the header of the frame in flight
    drop_silent_a: assert property (
        @(posedge clk) disable iff (rst)
        rx_payload_valid |-> match_now
    );

endmodule

`default_nettype wire

// File: hdl/udp_frame_builder.sv
`default_nettype none

module udp_frame_builder #(
    parameter udp_pkg::mac_t  LOCAL_MAC  = 48'h11_22_33_44_55_66,
    parameter udp_pkg::ip_t   LOCAL_IP   = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter udp_pkg::port_t LOCAL_PORT = 16'd1234
) (
    input  wire                  clk,
    input  wire                  rst,

    // header request
    input  wire                  tx_hdr_valid,
    output logic                 tx_hdr_ready,
    input  wire udp_pkg::mac_t   tx_dest_mac,
    input  wire udp_pkg::ip_t    tx_dest_ip,
    input  wire udp_pkg::port_t  tx_dest_port,
    input  wire udp_pkg::len_t   tx_length,

    // payload in
    input  wire udp_pkg::byte_t  tx_payload_data,
    input  wire                  tx_payload_valid,
    input  wire                  tx_payload_last,
    output logic                 tx_payload_ready,

    // frame out
    output udp_pkg::byte_t       eth_tx_data,
    output logic                 eth_tx_valid,
    output logic                 eth_tx_last,
    input  wire                  eth_tx_ready
);

    localparam int ETH_HDR_BYTES =
        udp_pkg::HDR_BYTES - udp_pkg::IP_HDR_BYTES - udp_pkg::UDP_HDR_BYTES;
    localparam logic [5:0] LAST_IDX = 6'(udp_pkg::HDR_BYTES - 1);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_HDR  = 2'd1;
    localparam logic [1:0] ST_PAY  = 2'd2;

    logic [1:0]     state;
    logic [5:0]     idx;
    udp_pkg::hdr_u  hdr_next;
    udp_pkg::hdr_u  hdr_reg;
    udp_pkg::len_t  len_reg;
    udp_pkg::len_t  pay_cnt;
    logic           hdr_xfer;
    logic           pay_xfer;

    // ones-complement sum over the ten ip header words, folded twice
    function automatic logic [15:0] ip_header_sum(input udp_pkg::hdr_u h);
        logic [19:0] sum;
        sum = '0;
        for (int i = 0; i < udp_pkg::IP_HDR_BYTES / 2; i++) begin
            sum = sum + 20'({h.bytes[ETH_HDR_BYTES + 2 * i],
                             h.bytes[ETH_HDR_BYTES + 2 * i + 1]});
        end
        sum = {4'd0, sum[15:0]} + {16'd0, sum[19:16]};
        sum = {4'd0, sum[15:0]} + {16'd0, sum[19:16]};
        return ~sum[15:0];
    endfunction

    // ident, flags and udp checksum stay zero from the clear
    always_comb begin
        hdr_next                    = '0;
        hdr_next.fields.dest_mac    = tx_dest_mac;
        hdr_next.fields.src_mac     = LOCAL_MAC;
        hdr_next.fields.eth_type    = udp_pkg::ETH_TYPE_IPV4;
        hdr_next.fields.ver_ihl     = 8'h45;
        hdr_next.fields.ip_length   =
            tx_length + 16'(udp_pkg::IP_HDR_BYTES + udp_pkg::UDP_HDR_BYTES);
        hdr_next.fields.ttl         = udp_pkg::IP_TTL;
        hdr_next.fields.protocol    = udp_pkg::IP_PROTO_UDP;
        hdr_next.fields.src_ip      = LOCAL_IP;
        hdr_next.fields.dest_ip     = tx_dest_ip;
        hdr_next.fields.src_port    = LOCAL_PORT;
        hdr_next.fields.dest_port   = tx_dest_port;
        hdr_next.fields.udp_length  = tx_length + 16'(udp_pkg::UDP_HDR_BYTES);
        // checksum word is still zero here
        hdr_next.fields.ip_checksum = ip_header_sum(hdr_next);
    end

    assign tx_hdr_ready     = (state == ST_IDLE);
    assign tx_payload_ready = (state == ST_PAY) && eth_tx_ready;

    assign eth_tx_valid = (state == ST_HDR) || ((state == ST_PAY) && tx_payload_valid);
    assign eth_tx_data  = (state == ST_HDR) ? hdr_reg.bytes[0] : tx_payload_data;
    assign eth_tx_last  = (state == ST_PAY) && tx_payload_last;

    assign hdr_xfer = (state == ST_HDR) && eth_tx_ready;
    assign pay_xfer = tx_payload_valid && tx_payload_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (tx_hdr_valid) begin
                        state <= ST_HDR;
                        idx   <= '0;
                    end
                end
                ST_HDR: begin
                    if (hdr_xfer) begin
                        idx <= idx + 6'd1;
                        if (idx == LAST_IDX) begin
                            state <= ST_PAY;
                        end
                    end
                end
                ST_PAY: begin
                    if (pay_xfer && tx_payload_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // header load, then one byte out of the front per transfer
    always_ff @(posedge clk) begin
        if (tx_hdr_valid && tx_hdr_ready) begin
            hdr_reg <= hdr_next;
            len_reg <= tx_length;
            pay_cnt <= '0;
        end else begin
            if (hdr_xfer) begin
                hdr_reg.bytes <= {hdr_reg.bytes[1:udp_pkg::HDR_BYTES-1], 8'h00};
            end
            if (pay_xfer) begin
                pay_cnt <= pay_cnt + 16'd1;
            end
        end
    end

    // user payload must match the length promised in the request
    pay_len_a: assert property (
        @(posedge clk) disable iff (rst)
        (pay_xfer && tx_payload_last) |-> (pay_cnt + 16'd1 == len_reg)
    );

endmodule

`default_nettype wire

// File: hdl/udp_stack_top.sv
`default_nettype none

module udp_stack_top #(
    parameter udp_pkg::mac_t  LOCAL_MAC  = 48'h11_22_33_44_55_66,
    parameter udp_pkg::ip_t   LOCAL_IP   = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter udp_pkg::port_t LOCAL_PORT = 16'd1234
) (
    input  wire                  clk,
    input  wire                  rst,

    // receive frame in
    input  wire udp_pkg::byte_t  rx_data,
    input  wire                  rx_valid,
    input  wire                  rx_last,
    output wire                  rx_ready,

    // receive payload out
    output wire udp_pkg::byte_t  rx_payload_data,
    output wire                  rx_payload_valid,
    output wire                  rx_payload_last,
    output wire udp_pkg::len_t   rx_payload_length,
    input  wire                  rx_payload_ready,

    // transmit request
    input  wire                  tx_hdr_valid,
    input  wire udp_pkg::mac_t   tx_dest_mac,
    input  wire udp_pkg::ip_t    tx_dest_ip,
    input  wire udp_pkg::port_t  tx_dest_port,
    input  wire udp_pkg::len_t   tx_length,
    output wire                  tx_hdr_ready,

    // transmit payload in
    input  wire udp_pkg::byte_t  tx_payload_data,
    input  wire                  tx_payload_valid,
    input  wire                  tx_payload_last,
    output wire                  tx_payload_ready,

    // transmit frame out
    output wire udp_pkg::byte_t  eth_tx_data,
    output wire                  eth_tx_valid,
    output wire                  eth_tx_last,
    input  wire                  eth_tx_ready
);

    // parser to filter
    wire udp_pkg::hdr_u   hdr;
    wire                  hdr_done;
    wire                  short_last;
    wire udp_pkg::byte_t  body_data;
    wire                  body_valid;
    wire                  body_last;
    wire                  body_ready;

    udp_frame_parser udp_frame_parser_i (
        .clk        (clk),
        .rst        (rst),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_last    (rx_last),
        .rx_ready   (rx_ready),
        .hdr        (hdr),
        .hdr_done   (hdr_done),
        .body_data  (body_data),
        .body_valid (body_valid),
        .body_last  (body_last),
        .body_ready (body_ready),
        .short_last (short_last)
    );

    udp_port_filter #(
        .LOCAL_PORT (LOCAL_PORT)
    ) udp_port_filter_i (
        .clk               (clk),
        .rst               (rst),
        .hdr               (hdr),
        .hdr_done          (hdr_done),
        .short_last        (short_last),
        .body_data         (body_data),
        .body_valid        (body_valid),
        .body_last         (body_last),
        .body_ready        (body_ready),
        .rx_payload_data   (rx_payload_data),
        .rx_payload_valid  (rx_payload_valid),
        .rx_payload_last   (rx_payload_last),
        .rx_payload_ready  (rx_payload_ready),
        .rx_payload_length (rx_payload_length)
    );

    // transmit side runs on its own
    udp_frame_builder #(
        .LOCAL_MAC  (LOCAL_MAC),
        .LOCAL_IP   (LOCAL_IP),
        .LOCAL_PORT (LOCAL_PORT)
    ) udp_frame_builder_i (
        .clk              (clk),
        .rst              (rst),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_dest_mac      (tx_dest_mac),
        .tx_dest_ip       (tx_dest_ip),
        .tx_dest_port     (tx_dest_port),
        .tx_length        (tx_length),
        .tx_payload_data  (tx_payload_data),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_last  (tx_payload_last),
        .tx_payload_ready (tx_payload_ready),
        .eth_tx_data      (eth_tx_data),
        .eth_tx_valid     (eth_tx_valid),
        .eth_tx_last      (eth_tx_last),
        .eth_tx_ready     (eth_tx_ready)
    );

endmodule

`default_nettype wire

// File: tb/tb_udp_frames.svh
`ifndef TB_UDP_FRAMES_SVH
`define TB_UDP_FRAMES_SVH

// 32-bit fibonacci lfsr, taps 32 22 2 1
function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_step()};
    end
    return r;
endfunction

// header bytes in wire order, ip checksum filled in
task automatic build_header(input udp_pkg::mac_t dmac, input udp_pkg::mac_t smac,
                            input logic [15:0] etype, input udp_pkg::byte_t proto,
                            input udp_pkg::ip_t sip, input udp_pkg::ip_t dip,
                            input udp_pkg::port_t sp, input udp_pkg::port_t dp,
                            input udp_pkg::len_t plen);
    logic [15:0] ip_len;
    logic [15:0] udp_len;
    logic [31:0] sum;
    ip_len  = plen + 16'd28;
    udp_len = plen + 16'd8;
    for (int i = 0; i < 6; i++) begin
        hdr_bytes[i]     = dmac[47 - 8 * i -: 8];
        hdr_bytes[6 + i] = smac[47 - 8 * i -: 8];
    end
    {hdr_bytes[12], hdr_bytes[13]} = etype;
    {hdr_bytes[14], hdr_bytes[15]} = 16'h4500;
    {hdr_bytes[16], hdr_bytes[17]} = ip_len;
    {hdr_bytes[18], hdr_bytes[19], hdr_bytes[20], hdr_bytes[21]} = 32'd0;
    hdr_bytes[22] = 8'd64;
    hdr_bytes[23] = proto;
    {hdr_bytes[24], hdr_bytes[25]} = 16'd0;
    {hdr_bytes[26], hdr_bytes[27], hdr_bytes[28], hdr_bytes[29]} = sip;
    {hdr_bytes[30], hdr_bytes[31], hdr_bytes[32], hdr_bytes[33]} = dip;
    {hdr_bytes[34], hdr_bytes[35]} = sp;
    {hdr_bytes[36], hdr_bytes[37]} = dp;
    {hdr_bytes[38], hdr_bytes[39]} = udp_len;
    {hdr_bytes[40], hdr_bytes[41]} = 16'd0;
    // ones-complement sum of the ten ip words
    sum = '0;
    for (int i = 14; i < 34; i += 2) begin
        sum = sum + {16'd0, hdr_bytes[i], hdr_bytes[i + 1]};
    end
    while (sum[31:16] != 16'd0) begin
        sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    end
    {hdr_bytes[24], hdr_bytes[25]} = ~sum[15:0];
endtask

function automatic bit would_deliver(input logic [15:0] etype, input udp_pkg::byte_t proto,
                                     input udp_pkg::port_t dport, input bit complete);
    return complete && etype == 16'h0800 && proto == 8'd17 && dport == LOCAL_PORT;
endfunction

task automatic check_byte(input string name, input udp_pkg::byte_t got,
                          input udp_pkg::byte_t exp);
    if (got !== exp) begin
        $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        $display("Errors found");
        $fatal(1, "byte mismatch");
    end
endtask

task automatic check_len(input string name, input udp_pkg::len_t got,
                         input udp_pkg::len_t exp);
    if (got !== exp) begin
        $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        $display("Errors found");
        $fatal(1, "length mismatch");
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        $display("Errors found");
        $fatal(1, "flag mismatch");
    end
endtask

task automatic add_rx_frame(input int kind);
    udp_pkg::len_t  plen;
    logic [15:0]    etype;
    udp_pkg::byte_t proto;
    udp_pkg::port_t dport;
    udp_pkg::byte_t b;
    int             n;
    bit             keep;
    plen  = 16'(1 + rand_bits(5));
    etype = (kind == K_ETYPE) ? 16'h86dd : 16'h0800;
    proto = (kind == K_PROTO) ? 8'd6 : 8'd17;
    dport = (kind == K_PORT) ? 16'd1235 : 16'd1234;
    build_header({16'h0200, rand_bits(32)}, 48'h0a0b0c0d0e0f, etype, proto,
                 32'h0a000001, LOCAL_IP, 16'd5000, dport, plen);
    n = (kind == K_SHORT) ? 10 + int'(rand_bits(4)) : udp_pkg::HDR_BYTES;
    for (int i = 0; i < n; i++) begin
        rx_q.push_back(hdr_bytes[i]);
        rx_last_q.push_back(kind == K_SHORT && i == n - 1);
    end
    keep = would_deliver(etype, proto, dport, kind != K_SHORT);
    if (kind != K_SHORT) begin
        for (int i = 0; i < int'(plen); i++) begin
            b = 8'(rand_bits(8));
            rx_q.push_back(b);
            rx_last_q.push_back(i == int'(plen) - 1);
            if (keep) begin
                exp_rx.push_back(b);
                exp_rx_last.push_back(i == int'(plen) - 1);
                exp_rx_len.push_back(plen);
            end
        end
        total_bytes += int'(plen);
    end
    total_bytes += n;
    frames++;
endtask

task automatic add_tx_request();
    udp_pkg::mac_t  dmac;
    udp_pkg::ip_t   dip;
    udp_pkg::port_t dp;
    udp_pkg::len_t  plen;
    udp_pkg::byte_t b;
    dmac = {16'h0010, rand_bits(32)};
    dip  = rand_bits(32);
    dp   = 16'(rand_bits(16));
    plen = 16'(1 + rand_bits(5));
    req_mac.push_back(dmac);
    req_ip.push_back(dip);
    req_port.push_back(dp);
    req_len.push_back(plen);
    build_header(dmac, LOCAL_MAC, 16'h0800, 8'd17, LOCAL_IP, dip, LOCAL_PORT, dp, plen);
    for (int i = 0; i < udp_pkg::HDR_BYTES; i++) begin
        exp_tx.push_back(hdr_bytes[i]);
        exp_tx_last.push_back(1'b0);
    end
    for (int i = 0; i < int'(plen); i++) begin
        b = 8'(rand_bits(8));
        txp_q.push_back(b);
        txp_last_q.push_back(i == int'(plen) - 1);
        exp_tx.push_back(b);
        exp_tx_last.push_back(i == int'(plen) - 1);
    end
    total_bytes += int'(plen);
    frames++;
endtask

`endif

// File: tb/tb_udp_stack.sv
`default_nettype none

module tb_udp_stack;

    localparam udp_pkg::mac_t  LOCAL_MAC  = 48'h11_22_33_44_55_66;
    localparam udp_pkg::ip_t   LOCAL_IP   = 32'hc0_a8_01_80;
    localparam udp_pkg::port_t LOCAL_PORT = 16'd1234;

    // receive frame kinds
    localparam int K_GOOD  = 0;
    localparam int K_PORT  = 1;
    localparam int K_ETYPE = 2;
    localparam int K_PROTO = 3;
    localparam int K_SHORT = 4;

    logic clk = 1'b0;
    logic rst;
    udp_pkg::byte_t rx_data;
    logic rx_valid;
    logic rx_last;
    logic rx_ready;
    udp_pkg::byte_t rx_payload_data;
    logic rx_payload_valid;
    logic rx_payload_last;
    logic rx_payload_ready;
    udp_pkg::len_t rx_payload_length;
    logic tx_hdr_valid;
    logic tx_hdr_ready;
    udp_pkg::mac_t tx_dest_mac;
    udp_pkg::ip_t tx_dest_ip;
    udp_pkg::port_t tx_dest_port;
    udp_pkg::len_t tx_length;
    udp_pkg::byte_t tx_payload_data;
    logic tx_payload_valid;
    logic tx_payload_last;
    logic tx_payload_ready;
    udp_pkg::byte_t eth_tx_data;
    logic eth_tx_valid;
    logic eth_tx_last;
    logic eth_tx_ready;

    logic [31:0] lfsr_state = 32'he0553acc;
    udp_pkg::byte_t hdr_bytes [udp_pkg::HDR_BYTES];
    int cycles = 0;
    int limit = 100000;
    int total_bytes = 0;
    int frames = 0;

    // stimulus streams
    udp_pkg::byte_t rx_q [$];
    logic           rx_last_q [$];
    udp_pkg::mac_t  req_mac [$];
    udp_pkg::ip_t   req_ip [$];
    udp_pkg::port_t req_port [$];
    udp_pkg::len_t  req_len [$];
    udp_pkg::byte_t txp_q [$];
    logic           txp_last_q [$];
    // expected outputs
    udp_pkg::byte_t exp_rx [$];
    logic           exp_rx_last [$];
    udp_pkg::len_t  exp_rx_len [$];
    udp_pkg::byte_t exp_tx [$];
    logic           exp_tx_last [$];

    `include "tb_udp_frames.svh"

    always #10 clk = ~clk;

    udp_stack_top #(
        .LOCAL_MAC  (LOCAL_MAC),
        .LOCAL_IP   (LOCAL_IP),
        .LOCAL_PORT (LOCAL_PORT)
    ) udp_stack_top_i (
        .clk               (clk),
        .rst               (rst),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .rx_last           (rx_last),
        .rx_ready          (rx_ready),
        .rx_payload_data   (rx_payload_data),
        .rx_payload_valid  (rx_payload_valid),
        .rx_payload_last   (rx_payload_last),
        .rx_payload_length (rx_payload_length),
        .rx_payload_ready  (rx_payload_ready),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_dest_mac       (tx_dest_mac),
        .tx_dest_ip        (tx_dest_ip),
        .tx_dest_port      (tx_dest_port),
        .tx_length         (tx_length),
        .tx_hdr_ready      (tx_hdr_ready),
        .tx_payload_data   (tx_payload_data),
        .tx_payload_valid  (tx_payload_valid),
        .tx_payload_last   (tx_payload_last),
        .tx_payload_ready  (tx_payload_ready),
        .eth_tx_data       (eth_tx_data),
        .eth_tx_valid      (eth_tx_valid),
        .eth_tx_last       (eth_tx_last),
        .eth_tx_ready      (eth_tx_ready)
    );

    task automatic drive_rx();
        logic got;
        while (rx_q.size() > 0) begin
            // occasional idle cycle between bytes
            if (rand_bits(2) == 32'd0) begin
                rx_valid = 1'b0;
                @(posedge clk);
                #2;
            end
            rx_data  = rx_q.pop_front();
            rx_last  = rx_last_q.pop_front();
            rx_valid = 1'b1;
            do begin
                @(negedge clk);
                got = rx_ready;
                @(posedge clk);
            end while (!got);
            #2;
        end
        rx_valid = 1'b0;
    endtask

    task automatic drive_tx_hdr();
        logic got;
        while (req_len.size() > 0) begin
            tx_dest_mac  = req_mac.pop_front();
            tx_dest_ip   = req_ip.pop_front();
            tx_dest_port = req_port.pop_front();
            tx_length    = req_len.pop_front();
            tx_hdr_valid = 1'b1;
            do begin
                @(negedge clk);
                got = tx_hdr_ready;
                @(posedge clk);
            end while (!got);
            #2;
            tx_hdr_valid = 1'b0;
        end
    endtask

    task automatic drive_tx_payload();
        logic got;
        while (txp_q.size() > 0) begin
            if (rand_bits(2) == 32'd0) begin
                tx_payload_valid = 1'b0;
                @(posedge clk);
                #2;
            end
            tx_payload_data  = txp_q.pop_front();
            tx_payload_last  = txp_last_q.pop_front();
            tx_payload_valid = 1'b1;
            do begin
                @(negedge clk);
                got = tx_payload_ready;
                @(posedge clk);
            end while (!got);
            #2;
        end
        tx_payload_valid = 1'b0;
    endtask

    // random back-pressure from both sinks
    initial begin
        forever begin
            @(posedge clk);
            #2;
            rx_payload_ready = (rand_bits(2) != 32'd0);
            eth_tx_ready     = (rand_bits(2) != 32'd0);
        end
    end

    // compare every output transfer, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && rx_payload_valid && rx_payload_ready) begin
            if (exp_rx.size() == 0) begin
                $display("receive payload byte arrived when none was expected");
                $display("Errors found");
                $fatal(1, "unexpected receive beat");
            end else begin
                check_byte("rx_payload_data", rx_payload_data, exp_rx.pop_front());
                check_flag("rx_payload_last", rx_payload_last, exp_rx_last.pop_front());
                check_len("rx_payload_length", rx_payload_length, exp_rx_len.pop_front());
            end
        end
        if (!rst && eth_tx_valid && eth_tx_ready) begin
            if (exp_tx.size() == 0) begin
                $display("transmit byte arrived when none was expected");
                $display("Errors found");
                $fatal(1, "unexpected transmit beat");
            end else begin
                check_byte("eth_tx_data", eth_tx_data, exp_tx.pop_front());
                check_flag("eth_tx_last", eth_tx_last, exp_tx_last.pop_front());
            end
        end
    end

    initial begin
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with transfers still outstanding", cycles);
        $display("Errors found");
        $fatal(1, "timeout");
    end

    initial begin
        rst = 1'b1;
        rx_data = '0;
        rx_valid = 1'b0;
        rx_last = 1'b0;
        rx_payload_ready = 1'b0;
        tx_hdr_valid = 1'b0;
        tx_dest_mac = '0;
        tx_dest_ip = '0;
        tx_dest_port = '0;
        tx_length = '0;
        tx_payload_data = '0;
        tx_payload_valid = 1'b0;
        tx_payload_last = 1'b0;
        eth_tx_ready = 1'b0;
        // each rejected or short frame is followed by a good one
        add_rx_frame(K_GOOD);
        add_rx_frame(K_PORT);
        add_rx_frame(K_GOOD);
        add_rx_frame(K_ETYPE);
        add_rx_frame(K_GOOD);
        add_rx_frame(K_PROTO);
        add_rx_frame(K_GOOD);
        add_rx_frame(K_SHORT);
        add_rx_frame(K_GOOD);
        repeat (4) add_rx_frame(K_GOOD);
        repeat (6) add_tx_request();
        limit = 4 * (total_bytes + 42 * frames) + 200;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        fork
            drive_rx();
            drive_tx_hdr();
            drive_tx_payload();
        join
        // last input beats carry the last output beats, so the queues are done here
        repeat (20) @(posedge clk);
        if (exp_rx.size() != 0 || exp_tx.size() != 0) begin
            $display("expected output bytes were never produced");
            $display("Errors found");
            $fatal(1, "queues not empty");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tb
hdl/udp_pkg.sv
hdl/udp_frame_parser.sv
hdl/udp_port_filter.sv
hdl/udp_frame_builder.sv
hdl/udp_stack_top.sv
tb/tb_udp_stack.sv

// File: run.sh
#!/bin/sh
# build and run the UDP stack testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module tb_udp_stack -o sim_udp_stack
./obj_dir/sim_udp_stack
